/* logic/ooo_pkg.sv */
// ####################################################################
// Shared sizes and vector types for the rename and retire slice.
// All sizes are fixed here; no module takes a parameter.
// NUM_PREGS must exceed NUM_AREGS; the difference is the free pool.
// Depths are powers of two so pointers wrap by plain overflow.
// ####################################################################

package ooo_pkg;

    // Register file and buffer sizes
    localparam int NUM_AREGS     = 16;
    localparam int NUM_PREGS     = 32;
    localparam int ROB_DEPTH     = 16;
    localparam int NUM_FREE_INIT = NUM_PREGS - NUM_AREGS;

    // Pointer widths derived from the depths
    localparam int AREG_W    = $clog2(NUM_AREGS);
    localparam int PREG_W    = $clog2(NUM_PREGS);
    localparam int FL_PTR_W  = $clog2(NUM_PREGS);
    localparam int ROB_PTR_W = $clog2(ROB_DEPTH);
    localparam int WORD_W    = 32;

    // Payload of one ROB entry holds pc, inst, prd and old_prd
    localparam int ROB_ENTRY_W = 2 * WORD_W + 2 * PREG_W;

    // Register numbers
    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;

    // ROB index and occupancy (one extra bit to tell full from empty)
    typedef logic [ROB_PTR_W-1:0] rob_idx_t;
    typedef logic [ROB_PTR_W:0]   rob_cnt_t;

    // Free list pointers and count
    typedef logic [FL_PTR_W-1:0] fl_ptr_t;
    typedef logic [FL_PTR_W:0]   fl_cnt_t;

    // PC or instruction word
    typedef logic [WORD_W-1:0] word_t;

    typedef logic [ROB_ENTRY_W-1:0] rob_entry_t;

endpackage

/* logic/rob_alloc_if.sv */
// ####################################################################
// One allocation from the rename unit into the reorder buffer.
// valid is high only in cycles where the dispatch is accepted;
// the ROB writes at idx on that edge. idx and full come from the ROB.
// ####################################################################

`timescale 1ns/1ps

interface rob_alloc_if
    import ooo_pkg::*;
();

    logic     valid;    // Accepted dispatch this cycle
    areg_t    rd;       // Architectural destination
    preg_t    prd;      // Newly allocated physical reg
    preg_t    old_prd;  // Mapping of rd before this dispatch
    word_t    pc;
    word_t    inst;
    rob_idx_t idx;      // ROB tail, where the entry lands
    logic     full;     // ROB cannot take another entry

    // Rename side produces the entry, sees where it goes
    modport rename (
        output valid, rd, prd, old_prd, pc, inst,
        input  idx, full
    );

    // ROB side consumes the entry, reports tail and fullness
    modport rob (
        input  valid, rd, prd, old_prd, pc, inst,
        output idx, full
    );

endinterface

/* logic/free_list.sv */
// ####################################################################
// Circular FIFO of free physical register numbers.
// Reset loads NUM_AREGS .. NUM_PREGS-1 in ascending order.
// Caller must not pop while empty; pushes never overflow because at
// most NUM_FREE_INIT registers can be free at any time.
// Pop and push may happen in the same cycle.
// ####################################################################

`timescale 1ns/1ps

module free_list
    import ooo_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  pop_i,
    input  logic  push_i,
    input  preg_t push_preg_i,
    output preg_t head_preg_o,
    output logic  empty_o
);

    // Storage for free register numbers
    preg_t   fl_mem [NUM_PREGS];
    fl_ptr_t head_q;
    fl_ptr_t tail_q;
    fl_cnt_t count_q;

    // Oldest free register is always offered
    assign head_preg_o = fl_mem[head_q];
    assign empty_o     = (count_q == '0);

    // Pointers and count
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= fl_ptr_t'(NUM_FREE_INIT);
            count_q <= fl_cnt_t'(NUM_FREE_INIT);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            // Net change only when exactly one side moves
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Contents
    // Reset loads the initial free pool
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_FREE_INIT; i++) begin
                fl_mem[i] <= preg_t'(NUM_AREGS + i);
            end
        end else if (push_i) begin
            // Retired register goes to the back of the line
            fl_mem[tail_q] <= push_preg_i;
        end
    end

endmodule

/* logic/rename_unit.sv */
// ####################################################################
// Destination renaming for one instruction per cycle.
// Map table resets to identity (areg a maps to preg a).
// stall_o is high while the ROB is full or no free reg is left;
// a dispatch during stall is dropped. Alloc outputs are
// combinational and only meaningful while stall_o is low.
// ####################################################################

`timescale 1ns/1ps

module rename_unit
    import ooo_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  dispatch_i,
    input  areg_t rd_i,
    input  word_t pc_i,
    input  word_t inst_i,
    input  logic  free_en_i,
    input  preg_t free_preg_i,
    rob_alloc_if.rename alloc,
    output logic  stall_o,
    output preg_t alloc_prd_o
);

    // Current speculative mapping of each architectural reg
    preg_t map_q [NUM_AREGS];

    logic  fl_empty;
    preg_t fl_head;
    logic  accept;

    // Freed regs come back from ROB commit
    free_list u_free_list (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pop_i       (accept),
        .push_i      (free_en_i),
        .push_preg_i (free_preg_i),
        .head_preg_o (fl_head),
        .empty_o     (fl_empty)
    );

    // Stall if either resource is exhausted
    assign stall_o = alloc.full | fl_empty;
    assign accept  = dispatch_i & ~stall_o;

    // Entry handed to the ROB
    assign alloc.valid   = accept;
    assign alloc.rd      = rd_i;
    assign alloc.prd     = fl_head;
    assign alloc.old_prd = map_q[rd_i];
    assign alloc.pc      = pc_i;
    assign alloc.inst    = inst_i;

    assign alloc_prd_o = fl_head;

    // Map update on accepted dispatch
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int a = 0; a < NUM_AREGS; a++) begin
                map_q[a] <= preg_t'(a);
            end
        end else if (accept) begin
            map_q[rd_i] <= fl_head;
        end
    end

endmodule

/* logic/rob.sv */
// ####################################################################
// Reorder buffer that allocates at the tail, completes by index and
// commits at the head, at most once per cycle and in program order.
// Head commits in the cycle after its done flag is set; commit_o and
// the free return are combinational from the head state.
// Completing an index that holds no live entry is not checked.
// ####################################################################

`timescale 1ns/1ps

module rob
    import ooo_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    rob_alloc_if.rob alloc,
    input  logic     complete_i,
    input  rob_idx_t complete_idx_i,
    output logic     commit_o,
    output word_t    commit_pc_o,
    output word_t    commit_inst_o,
    output preg_t    commit_prd_o,
    output logic     free_en_o,
    output preg_t    free_preg_o,
    output logic     empty_o,
    output logic     full_o
);

    // Per-entry status flags
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;

    // Payload as one packed word per entry
    rob_entry_t entry_q [ROB_DEPTH];

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;

    // Unpacked view of the head entry
    word_t head_pc;
    word_t head_inst;
    preg_t head_prd;
    preg_t head_old_prd;

    logic  commit;

    assign {head_pc, head_inst, head_prd, head_old_prd} = entry_q[head_q];

    // Occupancy
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == rob_cnt_t'(ROB_DEPTH));

    // Back to the rename unit
    assign alloc.idx  = tail_q;
    assign alloc.full = full_o;

    // Head leaves once it has finished
    assign commit = valid_q[head_q] & done_q[head_q];

    assign commit_o      = commit;
    assign commit_pc_o   = head_pc;
    assign commit_inst_o = head_inst;
    assign commit_prd_o  = head_prd;

    // Overwritten mapping is dead and goes back to the free list
    assign free_en_o   = commit;
    assign free_preg_o = head_old_prd;

    // Control state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // Retire head
            if (commit) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            // Execution finished for this index
            if (complete_i) begin
                done_q[complete_idx_i] <= 1'b1;
            end
            // New entry at tail starts not done; last write wins
            if (alloc.valid) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            case ({alloc.valid, commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload write at the tail
    always_ff @(posedge clk_i) begin
        if (alloc.valid) begin
            entry_q[tail_q] <= {alloc.pc, alloc.inst, alloc.prd, alloc.old_prd};
        end
    end

endmodule

/* logic/rename_rob_top.sv */
// ####################################################################
// Rename and retire slice: rename unit plus reorder buffer.
// Dispatch, completion and commit are single-cycle strobes with no
// handshake; stall_o is the only back-pressure.
// commit_old_prd_o is the register returned to the free list.
// ####################################################################

`timescale 1ns/1ps

module rename_rob_top
    import ooo_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     dispatch_i,
    input  areg_t    rd_i,
    input  word_t    pc_i,
    input  word_t    inst_i,
    input  logic     complete_i,
    input  rob_idx_t complete_idx_i,
    output logic     stall_o,
    output preg_t    alloc_prd_o,
    output rob_idx_t alloc_idx_o,
    output logic     commit_o,
    output word_t    commit_pc_o,
    output word_t    commit_inst_o,
    output preg_t    commit_prd_o,
    output preg_t    commit_old_prd_o,
    output logic     empty_o,
    output logic     full_o
);

    // Allocation bundle between rename and ROB
    rob_alloc_if alloc_if ();

    // Free return path
    logic  free_en;
    preg_t free_preg;

    rename_unit u_rename (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .dispatch_i  (dispatch_i),
        .rd_i        (rd_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .free_en_i   (free_en),
        .free_preg_i (free_preg),
        .alloc       (alloc_if.rename),
        .stall_o     (stall_o),
        .alloc_prd_o (alloc_prd_o)
    );

    rob u_rob (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc          (alloc_if.rob),
        .complete_i     (complete_i),
        .complete_idx_i (complete_idx_i),
        .commit_o       (commit_o),
        .commit_pc_o    (commit_pc_o),
        .commit_inst_o  (commit_inst_o),
        .commit_prd_o   (commit_prd_o),
        .free_en_o      (free_en),
        .free_preg_o    (free_preg),
        .empty_o        (empty_o),
        .full_o         (full_o)
    );

    // Tail index the dispatch lands in
    assign alloc_idx_o      = alloc_if.idx;
    assign commit_old_prd_o = free_preg;

endmodule

/* test/tb_rename_rob.sv */
// ####################################################################
// Testbench for the rename and retire slice.
// A reference model of map table, free list and program order is
// stepped at every falling edge and compared with the DUT outputs.
// Completions are random but only target live, unfinished entries.
// Stops at the first mismatch or timeout.
// ####################################################################

`timescale 1ns/1ps

module tb_rename_rob
    import ooo_pkg::*;
();

    logic     clk_i = 1'b0;
    logic     reset_i;
    logic     dispatch_i;
    logic     complete_i;
    areg_t    rd_i;
    word_t    pc_i;
    word_t    inst_i;
    rob_idx_t complete_idx_i;
    rob_idx_t alloc_idx_o;
    logic     stall_o;
    logic     commit_o;
    logic     empty_o;
    logic     full_o;
    preg_t    alloc_prd_o;
    preg_t    commit_prd_o;
    preg_t    commit_old_prd_o;
    word_t    commit_pc_o;
    word_t    commit_inst_o;

    // Reference model state
    preg_t    map_m [NUM_AREGS];
    logic     done_m [ROB_DEPTH];
    preg_t    free_q [$];
    preg_t    prd_q [$];
    preg_t    old_q [$];
    word_t    pc_q [$];
    word_t    inst_q [$];
    rob_idx_t idx_q [$];
    rob_idx_t tail_m;
    word_t    pc_next;
    integer   seed;
    int       overlap_cnt;

    rename_rob_top uut (.*);

    always #2 clk_i = ~clk_i;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    // Random live entry that has not been completed yet
    function automatic logic pick_pending(output rob_idx_t idx);
        rob_idx_t pend [$];
        int       sel;
        idx = '0;
        foreach (idx_q[i]) begin
            if (!done_m[idx_q[i]]) begin
                pend.push_back(idx_q[i]);
            end
        end
        if (pend.size() == 0) begin
            return 1'b0;
        end
        sel = int'($unsigned($random(seed)) % pend.size());
        idx = pend[sel];
        return 1'b1;
    endfunction

    // One cycle of stimulus applied just after the rising edge
    task automatic drive_cycle(input logic disp, input areg_t rd, input logic want_comp);
        rob_idx_t cidx;
        logic     comp;
        @(posedge clk_i);
        #1;
        cidx = '0;
        comp = want_comp && pick_pending(cidx);
        dispatch_i     = disp;
        rd_i           = rd;
        pc_i           = pc_next;
        inst_i         = $random(seed);
        complete_i     = comp;
        complete_idx_i = cidx;
        pc_next        = pc_next + 32'd4;
    endtask

    // Keep completing until the ROB is empty
    task automatic drain(input int limit);
        int n;
        n = 0;
        while (!empty_o && n < limit) begin
            drive_cycle(1'b0, '0, 1'b1);
            n++;
        end
        if (!empty_o) begin
            $display("Timeout: ROB still not empty after %0d cycles", limit);
            abort_run();
        end
    endtask

    // A dropped dispatch must leave the tail where it was
    assert property (@(posedge clk_i) disable iff (reset_i)
                     (dispatch_i && stall_o) |=> $stable(alloc_idx_o))
        else value_error("dispatch during stall moved the ROB tail");

    // Compare, then advance the model to the state after the next edge
    always @(negedge clk_i) begin : model_step
        logic exp_commit;
        logic exp_stall;
        if (!reset_i) begin
            exp_commit = (idx_q.size() != 0) && done_m[idx_q[0]];
            exp_stall  = (idx_q.size() == ROB_DEPTH) || (free_q.size() == 0);
            assert (empty_o == (idx_q.size() == 0) && full_o == (idx_q.size() == ROB_DEPTH))
                else value_error($sformatf("empty_o %0b full_o %0b, model holds %0d",
                                           empty_o, full_o, idx_q.size()));
            assert (stall_o == exp_stall)
                else value_error($sformatf("stall_o %0b, expected %0b", stall_o, exp_stall));
            assert (commit_o == exp_commit)
                else value_error($sformatf("commit_o %0b, expected %0b", commit_o, exp_commit));
            if (!exp_stall) begin
                assert (alloc_prd_o == free_q[0] && alloc_idx_o == tail_m)
                    else value_error($sformatf("alloc prd %0d idx %0d, expected %0d %0d",
                                               alloc_prd_o, alloc_idx_o, free_q[0], tail_m));
            end
            if (exp_commit) begin
                assert (commit_pc_o == pc_q[0] && commit_inst_o == inst_q[0])
                    else value_error($sformatf("commit pc %h inst %h, expected %h %h",
                                               commit_pc_o, commit_inst_o, pc_q[0], inst_q[0]));
                assert (commit_prd_o == prd_q[0] && commit_old_prd_o == old_q[0])
                    else value_error($sformatf("commit prd %0d old %0d, expected %0d %0d",
                                               commit_prd_o, commit_old_prd_o,
                                               prd_q[0], old_q[0]));
            end
            // Accepted dispatch takes the oldest free reg
            if (dispatch_i && !exp_stall) begin
                if (exp_commit) begin
                    overlap_cnt++;
                end
                idx_q.push_back(tail_m);
                pc_q.push_back(pc_i);
                inst_q.push_back(inst_i);
                old_q.push_back(map_m[rd_i]);
                prd_q.push_back(free_q.pop_front());
                map_m[rd_i]    = prd_q[$];
                done_m[tail_m] = 1'b0;
                tail_m         = tail_m + 1'b1;
            end
            // Retired entry hands back the mapping it overwrote
            if (exp_commit) begin
                free_q.push_back(old_q.pop_front());
                void'(idx_q.pop_front());
                void'(pc_q.pop_front());
                void'(inst_q.pop_front());
                void'(prd_q.pop_front());
            end
            if (complete_i) begin
                done_m[complete_idx_i] = 1'b1;
            end
        end
    end

    initial begin
        seed           = 32'h3eb83500;
        reset_i        = 1'b1;
        dispatch_i     = 1'b0;
        complete_i     = 1'b0;
        rd_i           = '0;
        pc_i           = '0;
        inst_i         = '0;
        complete_idx_i = '0;
        pc_next        = 32'h0000_1000;
        overlap_cnt    = 0;
        tail_m         = '0;
        for (int a = 0; a < NUM_AREGS; a++) begin
            map_m[a] = preg_t'(a);
        end
        for (int p = NUM_AREGS; p < NUM_PREGS; p++) begin
            free_q.push_back(preg_t'(p));
        end
        for (int e = 0; e < ROB_DEPTH; e++) begin
            done_m[e] = 1'b0;
        end
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        #1;
        assert (empty_o && !full_o && !stall_o && !commit_o)
            else value_error("outputs not in reset state");

        // Fill the ROB, then knock on it while full
        repeat (ROB_DEPTH) drive_cycle(1'b1, areg_t'($random(seed)), 1'b0);
        repeat (3) drive_cycle(1'b1, areg_t'($random(seed)), 1'b0);
        assert (full_o && stall_o)
            else value_error("ROB not full and stalled after 16 dispatches");

        // Random completion order with in-order retire
        drain(100);

        // Mixed traffic with dispatch and commit overlapping
        repeat (80) begin
            drive_cycle(($random(seed) & 3) != 0, areg_t'($random(seed)),
                        ($random(seed) & 1) != 0);
        end
        drain(100);
        drive_cycle(1'b0, '0, 1'b0);

        if (overlap_cnt == 0 || !empty_o || stall_o) begin
            value_error($sformatf("end state wrong: overlaps %0d empty %0b stall %0b",
                                  overlap_cnt, empty_o, stall_o));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* flist.f */
logic/ooo_pkg.sv
logic/rob_alloc_if.sv
logic/free_list.sv
logic/rename_unit.sv
logic/rob.sv
logic/rename_rob_top.sv
test/tb_rename_rob.sv

/* run.sh */
#!/bin/sh
# Compile and run the rename/ROB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rename_rob -Mdir obj_dir -f flist.f

status=0
out=$(./obj_dir/Vtb_rename_rob 2>&1) || status=$?
echo "$out"

# Pass only if the testbench printed its pass line
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
